//--- hw/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

    // cache geometry
    localparam int WAY_CNT    = 2;
    localparam int SET_CNT    = 256;
    // words per line, also the bus burst length
    localparam int LINE_WORDS = 4;

    // physical address split: tag | index | word offset | byte offset
    localparam int OFFSET_W   = 2;
    localparam int INDEX_W    = 8;
    localparam int TAG_W      = 20;
    localparam int INDEX_LSB  = OFFSET_W + 2;
    localparam int TAG_LSB    = INDEX_LSB + INDEX_W;

    // access size of a load or store
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // control states of the cache FSM
    typedef enum logic [2:0] {
        ST_IDLE    = 3'd0,
        ST_LOOKUP  = 3'd1,
        ST_WB_ADDR = 3'd2,
        ST_WB_DATA = 3'd3,
        ST_RF_ADDR = 3'd4,
        ST_RF_DATA = 3'd5,
        ST_RESPOND = 3'd6
    } miss_state_e;

endpackage

`default_nettype wire

//--- hw/dcache_ram.sv
`default_nettype none

module dcache_ram (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic [lsu_pkg::INDEX_W-1:0]  rd_index_i,
    input  wire logic [lsu_pkg::OFFSET_W-1:0] rd_offset_i,
    output logic [lsu_pkg::TAG_W-1:0]         tag_o,
    output logic                              valid_o,
    output logic                              dirty_o,
    output logic [31:0]                       rdata_o,
    input  wire logic [lsu_pkg::INDEX_W-1:0]  wr_index_i,
    input  wire logic [lsu_pkg::OFFSET_W-1:0] wr_offset_i,
    input  wire logic [3:0]                   data_be_i,
    input  wire logic [31:0]                  wdata_i,
    input  wire logic                         tag_we_i,
    input  wire logic [lsu_pkg::TAG_W-1:0]    tag_i,
    input  wire logic                         valid_i,
    input  wire logic                         dirty_i
);

    logic [lsu_pkg::TAG_W-1:0]    tag_mem [lsu_pkg::SET_CNT];
    logic [31:0]                  data_mem [lsu_pkg::SET_CNT * lsu_pkg::LINE_WORDS];
    logic [lsu_pkg::SET_CNT-1:0]  valid_q;
    logic [lsu_pkg::SET_CNT-1:0]  dirty_q;
    logic [lsu_pkg::INDEX_W-1:0]  rd_index_q;
    logic [lsu_pkg::OFFSET_W-1:0] rd_offset_q;

    // outputs follow the registered read address
    // so a write on the same edge is already visible
    always_ff @(posedge clk) begin
        rd_index_q  <= rd_index_i;
        rd_offset_q <= rd_offset_i;
    end

    assign tag_o   = tag_mem[rd_index_q];
    assign valid_o = valid_q[rd_index_q];
    assign dirty_o = dirty_q[rd_index_q];
    assign rdata_o = data_mem[{rd_index_q, rd_offset_q}];

    // byte lane writes
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (data_be_i[b]) begin
                data_mem[{wr_index_i, wr_offset_i}][b*8 +: 8] <= wdata_i[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tag_we_i) begin
            tag_mem[wr_index_i] <= tag_i;
        end
    end

    // line state bits
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
            dirty_q <= '0;
        end else if (tag_we_i) begin
            valid_q[wr_index_i] <= valid_i;
            dirty_q[wr_index_i] <= dirty_i;
        end
    end

endmodule

`default_nettype wire

//--- hw/dcache_miss_fsm.sv
`default_nettype none

module dcache_miss_fsm (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   req_accept_i,
    input  wire logic                   req_write_i,
    input  wire logic                   hit_i,
    input  wire logic                   victim_dirty_i,
    input  wire logic                   bus_ready_i,
    input  wire logic                   bus_rdata_valid_i,
    input  wire logic                   bus_rlast_i,
    output lsu_pkg::miss_state_e        state_o,
    output logic                        busy_o,
    output logic                        resp_valid_o,
    output logic                        store_we_o,
    output logic                        refill_we_o,
    output logic [lsu_pkg::OFFSET_W-1:0] word_cnt_o,
    output logic                        victim_advance_o,
    output logic                        bus_req_valid_o,
    output logic                        bus_req_write_o,
    output logic                        bus_wdata_valid_o,
    output logic                        bus_wlast_o
);

    lsu_pkg::miss_state_e          state_q;
    lsu_pkg::miss_state_e          state_d;
    logic [lsu_pkg::OFFSET_W-1:0]  cnt_q;
    logic                          last_word;
    logic                          wb_beat;

    assign last_word = int'(cnt_q) == lsu_pkg::LINE_WORDS - 1;
    assign wb_beat   = (state_q == lsu_pkg::ST_WB_DATA) && bus_ready_i;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= lsu_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            lsu_pkg::ST_IDLE: begin
                if (req_accept_i) begin
                    state_d = lsu_pkg::ST_LOOKUP;
                end
            end
            lsu_pkg::ST_LOOKUP: begin
                if (hit_i) begin
                    state_d = lsu_pkg::ST_RESPOND;
                end else if (victim_dirty_i) begin
                    state_d = lsu_pkg::ST_WB_ADDR;
                end else begin
                    state_d = lsu_pkg::ST_RF_ADDR;
                end
            end
            lsu_pkg::ST_WB_ADDR: begin
                if (bus_ready_i) begin
                    state_d = lsu_pkg::ST_WB_DATA;
                end
            end
            lsu_pkg::ST_WB_DATA: begin
                if (wb_beat && last_word) begin
                    state_d = lsu_pkg::ST_RF_ADDR;
                end
            end
            lsu_pkg::ST_RF_ADDR: begin
                if (bus_ready_i) begin
                    state_d = lsu_pkg::ST_RF_DATA;
                end
            end
            lsu_pkg::ST_RF_DATA: begin
                // retry the lookup once the line is in
                if (bus_rdata_valid_i && bus_rlast_i) begin
                    state_d = lsu_pkg::ST_LOOKUP;
                end
            end
            lsu_pkg::ST_RESPOND: begin
                // back to back request may start here
                if (req_accept_i) begin
                    state_d = lsu_pkg::ST_LOOKUP;
                end else begin
                    state_d = lsu_pkg::ST_IDLE;
                end
            end
            default: begin
                state_d = lsu_pkg::ST_IDLE;
            end
        endcase
    end

    // burst word counter, shared by writeback and refill
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else if (state_q == lsu_pkg::ST_LOOKUP) begin
            cnt_q <= '0;
        end else if (wb_beat || refill_we_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign state_o           = state_q;
    assign word_cnt_o        = cnt_q;
    assign busy_o            = (state_q != lsu_pkg::ST_IDLE) && (state_q != lsu_pkg::ST_RESPOND);
    assign resp_valid_o      = state_q == lsu_pkg::ST_RESPOND;
    assign store_we_o        = resp_valid_o && req_write_i;
    assign refill_we_o       = (state_q == lsu_pkg::ST_RF_DATA) && bus_rdata_valid_i;
    assign victim_advance_o  = refill_we_o && bus_rlast_i;

    assign bus_req_valid_o   = (state_q == lsu_pkg::ST_WB_ADDR) || (state_q == lsu_pkg::ST_RF_ADDR);
    assign bus_req_write_o   = state_q == lsu_pkg::ST_WB_ADDR;
    assign bus_wdata_valid_o = state_q == lsu_pkg::ST_WB_DATA;
    assign bus_wlast_o       = bus_wdata_valid_o && last_word;

endmodule

`default_nettype wire

//--- hw/lsu_data_align.sv
`default_nettype none

module lsu_data_align (
    input  wire lsu_pkg::access_size_e size_i,
    input  wire logic                  signed_i,
    input  wire logic [1:0]            addr_lo_i,
    input  wire logic [31:0]           store_data_i,
    input  wire logic [31:0]           load_word_i,
    output logic [3:0]                 byte_en_o,
    output logic [31:0]                store_word_o,
    output logic [31:0]                load_data_o
);

    logic [31:0] byte_lane;
    logic [31:0] half_lane;

    // addressed byte or half moved down to bit 0
    assign byte_lane = load_word_i >> {addr_lo_i, 3'b000};
    assign half_lane = load_word_i >> {addr_lo_i[1], 4'b0000};

    always_comb begin
        case (size_i)
            lsu_pkg::SIZE_BYTE: begin
                byte_en_o    = 4'b0001 << addr_lo_i;
                store_word_o = store_data_i << {addr_lo_i, 3'b000};
            end
            lsu_pkg::SIZE_HALF: begin
                byte_en_o    = 4'b0011 << {addr_lo_i[1], 1'b0};
                store_word_o = store_data_i << {addr_lo_i[1], 4'b0000};
            end
            default: begin
                byte_en_o    = 4'b1111;
                store_word_o = store_data_i;
            end
        endcase
    end

    always_comb begin
        case (size_i)
            lsu_pkg::SIZE_BYTE: load_data_o = {{24{signed_i & byte_lane[7]}}, byte_lane[7:0]};
            lsu_pkg::SIZE_HALF: load_data_o = {{16{signed_i & half_lane[15]}}, half_lane[15:0]};
            default:            load_data_o = load_word_i;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/way_select_lfsr.sv
`default_nettype none

module way_select_lfsr (
    input  wire logic clk,
    input  wire logic rst_n,
    input  wire logic advance_i,
    output logic      way_o
);

    logic [7:0] lfsr_q;
    logic       feedback;

    // taps 8,6,5,4 give all 255 nonzero states
    assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr_q <= 8'h5a;
        end else if (advance_i) begin
            lfsr_q <= {lfsr_q[6:0], feedback};
        end
    end

    assign way_o = lfsr_q[0];

endmodule

`default_nettype wire

//--- hw/dcache_lsu.sv
`default_nettype none

module dcache_lsu (
    input  wire logic                  clk,
    input  wire logic                  rst_n,
    input  wire logic                  req_valid_i,
    input  wire logic                  req_write_i,
    input  wire lsu_pkg::access_size_e req_size_i,
    input  wire logic                  req_signed_i,
    input  wire logic [31:0]           req_addr_i,
    input  wire logic [31:0]           req_wdata_i,
    output logic                       busy_o,
    output logic                       resp_valid_o,
    output logic [31:0]                resp_rdata_o,
    output logic                       bus_req_valid_o,
    output logic                       bus_req_write_o,
    output logic [31:0]                bus_req_addr_o,
    input  wire logic                  bus_ready_i,
    output logic                       bus_wdata_valid_o,
    output logic [31:0]                bus_wdata_o,
    output logic                       bus_wlast_o,
    input  wire logic                  bus_rdata_valid_i,
    input  wire logic [31:0]           bus_rdata_i,
    input  wire logic                  bus_rlast_i
);

    logic                          req_accept;
    logic                          write_q;
    lsu_pkg::access_size_e         size_q;
    logic                          signed_q;
    logic [31:0]                   addr_q;
    logic [31:0]                   wdata_q;

    lsu_pkg::miss_state_e          state;
    logic                          store_we;
    logic                          refill_we;
    logic [lsu_pkg::OFFSET_W-1:0]  word_cnt;
    logic                          victim_advance;
    logic                          victim_way;
    logic                          victim_dirty;

    logic [lsu_pkg::TAG_W-1:0]     way_tag [lsu_pkg::WAY_CNT];
    logic [31:0]                   way_rdata [lsu_pkg::WAY_CNT];
    logic [lsu_pkg::WAY_CNT-1:0]   way_valid;
    logic [lsu_pkg::WAY_CNT-1:0]   way_dirty;
    logic [lsu_pkg::WAY_CNT-1:0]   hit_vec;
    logic                          hit;
    logic                          hit_way;

    logic [lsu_pkg::INDEX_W-1:0]   index_q;
    logic [lsu_pkg::INDEX_W-1:0]   rd_index;
    logic [lsu_pkg::OFFSET_W-1:0]  rd_offset;
    logic [lsu_pkg::OFFSET_W-1:0]  wr_offset;
    logic [31:0]                   wr_data;
    logic                          wb_step;
    logic [3:0]                    store_be;
    logic [31:0]                   store_word;
    logic [31:0]                   load_data;

    assign req_accept = req_valid_i && !busy_o;
    assign index_q    = addr_q[lsu_pkg::INDEX_LSB +: lsu_pkg::INDEX_W];

    // request fields held for the whole access
    always_ff @(posedge clk) begin
        if (req_accept) begin
            write_q  <= req_write_i;
            size_q   <= req_size_i;
            signed_q <= req_signed_i;
            addr_q   <= req_addr_i;
            wdata_q  <= req_wdata_i;
        end
    end

    dcache_miss_fsm u_fsm (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_accept_i      (req_accept),
        .req_write_i       (write_q),
        .hit_i             (hit),
        .victim_dirty_i    (victim_dirty),
        .bus_ready_i       (bus_ready_i),
        .bus_rdata_valid_i (bus_rdata_valid_i),
        .bus_rlast_i       (bus_rlast_i),
        .state_o           (state),
        .busy_o            (busy_o),
        .resp_valid_o      (resp_valid_o),
        .store_we_o        (store_we),
        .refill_we_o       (refill_we),
        .word_cnt_o        (word_cnt),
        .victim_advance_o  (victim_advance),
        .bus_req_valid_o   (bus_req_valid_o),
        .bus_req_write_o   (bus_req_write_o),
        .bus_wdata_valid_o (bus_wdata_valid_o),
        .bus_wlast_o       (bus_wlast_o)
    );

    way_select_lfsr u_victim (
        .clk       (clk),
        .rst_n     (rst_n),
        .advance_i (victim_advance),
        .way_o     (victim_way)
    );

    lsu_data_align u_align (
        .size_i       (size_q),
        .signed_i     (signed_q),
        .addr_lo_i    (addr_q[1:0]),
        .store_data_i (wdata_q),
        .load_word_i  (way_rdata[hit_way]),
        .byte_en_o    (store_be),
        .store_word_o (store_word),
        .load_data_o  (load_data)
    );

    // writeback reads one word ahead so the bus word is ready at each beat
    assign wb_step = bus_wdata_valid_o && bus_ready_i;

    always_comb begin
        rd_index  = req_accept ? req_addr_i[lsu_pkg::INDEX_LSB +: lsu_pkg::INDEX_W] : index_q;
        rd_offset = req_accept ? req_addr_i[2 +: lsu_pkg::OFFSET_W] : addr_q[2 +: lsu_pkg::OFFSET_W];
        if (state == lsu_pkg::ST_WB_ADDR || state == lsu_pkg::ST_WB_DATA) begin
            rd_offset = word_cnt + {{(lsu_pkg::OFFSET_W-1){1'b0}}, wb_step};
        end
    end

    // refill beats take priority over store data
    assign wr_offset = refill_we ? word_cnt : addr_q[2 +: lsu_pkg::OFFSET_W];
    assign wr_data   = refill_we ? bus_rdata_i : store_word;

    for (genvar w = 0; w < lsu_pkg::WAY_CNT; w++) begin : g_way
        logic refill_sel;
        logic store_sel;

        assign refill_sel = refill_we && (victim_way == w);
        assign store_sel  = store_we && hit_vec[w];
        assign hit_vec[w] = way_valid[w]
                         && (way_tag[w] == addr_q[lsu_pkg::TAG_LSB +: lsu_pkg::TAG_W]);

        dcache_ram u_ram (
            .clk         (clk),
            .rst_n       (rst_n),
            .rd_index_i  (rd_index),
            .rd_offset_i (rd_offset),
            .tag_o       (way_tag[w]),
            .valid_o     (way_valid[w]),
            .dirty_o     (way_dirty[w]),
            .rdata_o     (way_rdata[w]),
            .wr_index_i  (index_q),
            .wr_offset_i (wr_offset),
            .data_be_i   (refill_sel ? 4'hf : (store_sel ? store_be : 4'h0)),
            .wdata_i     (wr_data),
            .tag_we_i    (refill_sel || store_sel),
            .tag_i       (addr_q[lsu_pkg::TAG_LSB +: lsu_pkg::TAG_W]),
            .valid_i     (1'b1),
            .dirty_i     (store_we)
        );
    end

    assign hit          = |hit_vec;
    // two ways, so a hit in way 1 selects it
    assign hit_way      = hit_vec[1];
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

    // line address of the victim for writeback, of the request for refill
    assign bus_req_addr_o = bus_req_write_o
        ? {way_tag[victim_way], index_q, {lsu_pkg::INDEX_LSB{1'b0}}}
        : {addr_q[31:lsu_pkg::INDEX_LSB], {lsu_pkg::INDEX_LSB{1'b0}}};
    assign bus_wdata_o    = way_rdata[victim_way];

    // stores answer with zero
    always_ff @(posedge clk) begin
        if (state == lsu_pkg::ST_LOOKUP && hit) begin
            resp_rdata_o <= write_q ? 32'h0 : load_data;
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    timeunit 1ns;
    timeprecision 100ps;

    // 100 ns period
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // reset held over the first 10 rising edges
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verification/tb_bus_memory.sv
`default_nettype none

module tb_bus_memory (
    input  wire logic        clk,
    input  wire logic        rst_n,
    input  wire logic        bus_req_valid_i,
    input  wire logic        bus_req_write_i,
    input  wire logic [31:0] bus_req_addr_i,
    output logic             bus_ready_o,
    input  wire logic        bus_wdata_valid_i,
    input  wire logic [31:0] bus_wdata_i,
    input  wire logic        bus_wlast_i,
    output logic             bus_rdata_valid_o,
    output logic [31:0]      bus_rdata_o,
    output logic             bus_rlast_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MEM_WORDS = 4096;

    logic [31:0] mem [MEM_WORDS];
    logic [11:0] wr_ptr;
    logic [11:0] rd_ptr;
    logic [2:0]  rd_left;
    logic [1:0]  wr_beat;
    // write beats whose last flag disagreed with the burst position
    int          wlast_errors;

    // start contents, a function of the full byte address
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h6a09_e667;
    endfunction

    initial begin
        void'($urandom(32'h874d_b304));
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = fill_word(i * 4);
        end
        bus_ready_o       = 1'b0;
        bus_rdata_valid_o = 1'b0;
        bus_rdata_o       = 32'h0;
        bus_rlast_o       = 1'b0;
        rd_left           = 3'd0;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            bus_ready_o       <= 1'b0;
            bus_rdata_valid_o <= 1'b0;
            bus_rlast_o       <= 1'b0;
            rd_left           <= 3'd0;
            wr_beat           <= 2'd0;
            wlast_errors      <= 0;
        end else begin
            // ready about three cycles in four
            bus_ready_o <= ($urandom % 4) != 0;
            if (bus_req_valid_i && bus_ready_o) begin
                if (bus_req_write_i) begin
                    wr_ptr  <= bus_req_addr_i[13:2];
                    wr_beat <= 2'd0;
                end else begin
                    rd_ptr  <= bus_req_addr_i[13:2];
                    rd_left <= 3'd4;
                end
            end
            if (bus_wdata_valid_i && bus_ready_o) begin
                mem[wr_ptr] <= bus_wdata_i;
                wr_ptr      <= wr_ptr + 12'd1;
                wr_beat     <= wr_beat + 2'd1;
                // last belongs on the fourth word only
                if (bus_wlast_i !== (wr_beat == 2'd3)) begin
                    wlast_errors <= wlast_errors + 1;
                end
            end
            // read words come back with random gaps
            bus_rdata_valid_o <= 1'b0;
            bus_rlast_o       <= 1'b0;
            if (rd_left != 3'd0 && ($urandom % 3) != 0) begin
                bus_rdata_valid_o <= 1'b1;
                bus_rdata_o       <= mem[rd_ptr];
                bus_rlast_o       <= rd_left == 3'd1;
                rd_ptr            <= rd_ptr + 12'd1;
                rd_left           <= rd_left - 3'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_dcache_lsu.sv
`default_nettype none

module tb_dcache_lsu;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int ENTRY_MAX  = 24;
    localparam int MEM_WORDS  = 4096;
    localparam int WAIT_LIMIT = 400;

    logic                  clk;
    logic                  rst_n;
    logic                  req_valid_i;
    logic                  req_write_i;
    lsu_pkg::access_size_e req_size_i;
    logic                  req_signed_i;
    logic [31:0]           req_addr_i;
    logic [31:0]           req_wdata_i;
    logic                  busy_o;
    logic                  resp_valid_o;
    logic [31:0]           resp_rdata_o;
    logic                  bus_req_valid_o;
    logic                  bus_req_write_o;
    logic [31:0]           bus_req_addr_o;
    logic                  bus_ready_i;
    logic                  bus_wdata_valid_o;
    logic [31:0]           bus_wdata_o;
    logic                  bus_wlast_o;
    logic                  bus_rdata_valid_i;
    logic [31:0]           bus_rdata_i;
    logic                  bus_rlast_i;

    // stimulus table, one request per entry
    string                 t_name   [ENTRY_MAX];
    logic                  t_write  [ENTRY_MAX];
    lsu_pkg::access_size_e t_size   [ENTRY_MAX];
    logic                  t_signed [ENTRY_MAX];
    logic [31:0]           t_addr   [ENTRY_MAX];
    logic [31:0]           t_wdata  [ENTRY_MAX];
    // expect a 2 cycle hit response
    logic                  t_hit    [ENTRY_MAX];
    // extra strobe while busy, and a check of the memory word
    logic                  t_poke   [ENTRY_MAX];
    logic                  t_memchk [ENTRY_MAX];
    int                    n_entries;

    // expected word contents as loads should see them
    logic [31:0]           shadow   [MEM_WORDS];

    tb_clock_gen clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tb_bus_memory bus_mem (
        .clk               (clk),
        .rst_n             (rst_n),
        .bus_req_valid_i   (bus_req_valid_o),
        .bus_req_write_i   (bus_req_write_o),
        .bus_req_addr_i    (bus_req_addr_o),
        .bus_ready_o       (bus_ready_i),
        .bus_wdata_valid_i (bus_wdata_valid_o),
        .bus_wdata_i       (bus_wdata_o),
        .bus_wlast_i       (bus_wlast_o),
        .bus_rdata_valid_o (bus_rdata_valid_i),
        .bus_rdata_o       (bus_rdata_i),
        .bus_rlast_o       (bus_rlast_i)
    );

    dcache_lsu UUT (
        .clk               (clk),
        .rst_n             (rst_n),
        .req_valid_i       (req_valid_i),
        .req_write_i       (req_write_i),
        .req_size_i        (req_size_i),
        .req_signed_i      (req_signed_i),
        .req_addr_i        (req_addr_i),
        .req_wdata_i       (req_wdata_i),
        .busy_o            (busy_o),
        .resp_valid_o      (resp_valid_o),
        .resp_rdata_o      (resp_rdata_o),
        .bus_req_valid_o   (bus_req_valid_o),
        .bus_req_write_o   (bus_req_write_o),
        .bus_req_addr_o    (bus_req_addr_o),
        .bus_ready_i       (bus_ready_i),
        .bus_wdata_valid_o (bus_wdata_valid_o),
        .bus_wdata_o       (bus_wdata_o),
        .bus_wlast_o       (bus_wlast_o),
        .bus_rdata_valid_i (bus_rdata_valid_i),
        .bus_rdata_i       (bus_rdata_i),
        .bus_rlast_i       (bus_rlast_i)
    );

    // same start pattern as the memory model
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return (addr * 32'h9e37_79b9) ^ 32'h6a09_e667;
    endfunction

    // addressed byte or half of a word, sign or zero extended
    function automatic logic [31:0] expected_load(input lsu_pkg::access_size_e size,
                                                  input logic sgn, input logic [31:0] word,
                                                  input logic [1:0] lo);
        logic [7:0]  b;
        logic [15:0] h;
        b = word[8*lo +: 8];
        h = lo[1] ? word[31:16] : word[15:0];
        case (size)
            lsu_pkg::SIZE_BYTE: return {{24{sgn & b[7]}}, b};
            lsu_pkg::SIZE_HALF: return {{16{sgn & h[15]}}, h};
            default:            return word;
        endcase
    endfunction

    task automatic apply_store(input lsu_pkg::access_size_e size, input logic [31:0] addr,
                               input logic [31:0] data);
        logic [31:0] word;
        word = shadow[addr[13:2]];
        case (size)
            lsu_pkg::SIZE_BYTE: word[8*addr[1:0] +: 8] = data[7:0];
            lsu_pkg::SIZE_HALF: word[16*addr[1] +: 16] = data[15:0];
            default:            word = data;
        endcase
        shadow[addr[13:2]] = word;
    endtask

    task automatic check_value(input string test_name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("error: %s expected 0x%08h actual 0x%08h", test_name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: %s", what);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic add_entry(input string name, input logic write,
                             input lsu_pkg::access_size_e size, input logic sgn,
                             input logic [31:0] addr, input logic [31:0] wdata,
                             input logic hit, input logic poke, input logic memchk);
        t_name[n_entries]   = name;
        t_write[n_entries]  = write;
        t_size[n_entries]   = size;
        t_signed[n_entries] = sgn;
        t_addr[n_entries]   = addr;
        t_wdata[n_entries]  = wdata;
        t_hit[n_entries]    = hit;
        t_poke[n_entries]   = poke;
        t_memchk[n_entries] = memchk;
        n_entries++;
    endtask

    task automatic build_table();
        n_entries = 0;
        // fresh line, then the same line again
        add_entry("load_miss",    0, lsu_pkg::SIZE_WORD, 0, 32'h0000_0100, 32'h0, 0, 0, 0);
        add_entry("load_hit",     0, lsu_pkg::SIZE_WORD, 0, 32'h0000_0100, 32'h0, 1, 0, 0);
        // stores of each size into the cached line
        add_entry("store_byte",   1, lsu_pkg::SIZE_BYTE, 0, 32'h0000_0101, 32'h0000_00a5, 1, 0, 0);
        add_entry("store_half",   1, lsu_pkg::SIZE_HALF, 0, 32'h0000_0106, 32'h0000_8001, 1, 0, 0);
        add_entry("store_word",   1, lsu_pkg::SIZE_WORD, 0, 32'h0000_0108, 32'hdead_beef, 1, 0, 0);
        add_entry("lb_signed",    0, lsu_pkg::SIZE_BYTE, 1, 32'h0000_0101, 32'h0, 1, 0, 0);
        add_entry("lb_unsigned",  0, lsu_pkg::SIZE_BYTE, 0, 32'h0000_0101, 32'h0, 1, 0, 0);
        add_entry("lh_signed",    0, lsu_pkg::SIZE_HALF, 1, 32'h0000_0106, 32'h0, 1, 0, 0);
        add_entry("lh_unsigned",  0, lsu_pkg::SIZE_HALF, 0, 32'h0000_0106, 32'h0, 1, 0, 0);
        add_entry("lw_merged",    0, lsu_pkg::SIZE_WORD, 0, 32'h0000_0100, 32'h0, 1, 0, 0);
        add_entry("lb_top",       0, lsu_pkg::SIZE_BYTE, 1, 32'h0000_010b, 32'h0, 1, 0, 0);
        add_entry("lh_low",       0, lsu_pkg::SIZE_HALF, 0, 32'h0000_0108, 32'h0, 1, 0, 0);
        add_entry("lb_fill",      0, lsu_pkg::SIZE_BYTE, 0, 32'h0000_010e, 32'h0, 1, 0, 0);
        // three tags on set 0x30
        add_entry("evict_st_a",   1, lsu_pkg::SIZE_WORD, 0, 32'h0000_0304, 32'h1234_5678, 0, 0, 0);
        add_entry("evict_st_b",   1, lsu_pkg::SIZE_WORD, 0, 32'h0000_1304, 32'hcafe_f00d, 0, 0, 0);
        add_entry("evict_ld_c",   0, lsu_pkg::SIZE_WORD, 0, 32'h0000_2304, 32'h0, 0, 0, 0);
        add_entry("reload_a",     0, lsu_pkg::SIZE_WORD, 0, 32'h0000_0304, 32'h0, 0, 0, 1);
        add_entry("reload_b",     0, lsu_pkg::SIZE_WORD, 0, 32'h0000_1304, 32'h0, 1, 0, 0);
        // store strobe during lookup must be dropped
        add_entry("busy_strobe",  0, lsu_pkg::SIZE_WORD, 0, 32'h0000_0100, 32'h0, 1, 1, 0);
        add_entry("after_strobe", 0, lsu_pkg::SIZE_WORD, 0, 32'h0000_0104, 32'h0, 1, 0, 0);
    endtask

    task automatic wait_reset();
        int cycles;
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!rst_n && cycles < WAIT_LIMIT);
        if (!rst_n) fail_timeout("reset was never released");
    endtask

    task automatic run_entry(input int i);
        int          cycles;
        logic [11:0] widx;
        logic [31:0] rdata;
        logic [31:0] expected;
        widx   = t_addr[i][13:2];
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (busy_o && cycles < WAIT_LIMIT);
        if (busy_o) fail_timeout({"cache stayed busy before ", t_name[i]});

        @(posedge clk);
        req_valid_i  <= 1'b1;
        req_write_i  <= t_write[i];
        req_size_i   <= t_size[i];
        req_signed_i <= t_signed[i];
        req_addr_i   <= t_addr[i];
        req_wdata_i  <= t_wdata[i];
        // acceptance edge
        @(posedge clk);
        cycles = 0;
        if (t_poke[i]) begin
            // strobe stays high with a store to the next word
            req_write_i <= 1'b1;
            req_size_i  <= lsu_pkg::SIZE_WORD;
            req_addr_i  <= t_addr[i] + 32'd4;
            req_wdata_i <= ~shadow[widx + 12'd1];
            @(negedge clk);
            cycles = 1;
            check_value({t_name[i], " busy"}, 32'd1, busy_o);
            @(posedge clk);
        end
        req_valid_i <= 1'b0;

        do begin
            @(negedge clk);
            cycles++;
        end while (resp_valid_o !== 1'b1 && cycles < WAIT_LIMIT);
        if (resp_valid_o !== 1'b1) fail_timeout({"no response for ", t_name[i]});
        rdata = resp_rdata_o;

        if (t_hit[i]) check_value({t_name[i], " latency"}, 32'd2, cycles);
        if (t_write[i]) begin
            check_value(t_name[i], 32'h0, rdata);
            apply_store(t_size[i], t_addr[i], t_wdata[i]);
        end else begin
            expected = expected_load(t_size[i], t_signed[i], shadow[widx], t_addr[i][1:0]);
            check_value(t_name[i], expected, rdata);
        end
        // written back line must have reached the memory
        if (t_memchk[i]) check_value({t_name[i], " memory"}, shadow[widx], bus_mem.mem[widx]);
        // every write burst so far closed with last on its fourth word
        check_value({t_name[i], " wlast"}, 32'd0, bus_mem.wlast_errors);
    endtask

    initial begin
        req_valid_i  <= 1'b0;
        req_write_i  <= 1'b0;
        req_size_i   <= lsu_pkg::SIZE_WORD;
        req_signed_i <= 1'b0;
        req_addr_i   <= 32'h0;
        req_wdata_i  <= 32'h0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = fill_word(i * 4);
        end
        build_table();

        wait_reset();
        @(negedge clk);
        check_value("reset_busy", 32'h0, busy_o);
        check_value("reset_resp_valid", 32'h0, resp_valid_o);
        check_value("reset_bus_req", 32'h0, bus_req_valid_o);
        check_value("reset_bus_wdata", 32'h0, bus_wdata_valid_o);

        for (int i = 0; i < n_entries; i++) begin
            run_entry(i);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
hw/lsu_pkg.sv
hw/dcache_ram.sv
hw/dcache_miss_fsm.sv
hw/lsu_data_align.sv
hw/way_select_lfsr.sv
hw/dcache_lsu.sv
verification/tb_clock_gen.sv
verification/tb_bus_memory.sv
verification/tb_dcache_lsu.sv

//--- Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -Wno-fatal --top-module tb_dcache_lsu -f vlog.f \
		--Mdir $(OBJ_DIR) -o tb_dcache_lsu

run: compile
	./$(OBJ_DIR)/tb_dcache_lsu > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
